// File: hdl/trace_pkg.sv
// shared widths, types and encodings of the commit trace observer, imported by every block
package trace_pkg;

  // --------------------
  // widths and vector types
  // --------------------
  localparam int unsigned XLEN = 32;
  localparam int unsigned CNT_W = 32;
  localparam int unsigned APB_ADDR_W = 5;

  typedef logic [XLEN-1:0]       xlen_t;
  typedef logic [CNT_W-1:0]      cnt_t;
  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [6:0]            opcode_t;

  // privilege level as encoded by the core
  typedef logic [1:0] priv_lvl_t;
  localparam priv_lvl_t PRIV_LVL_M = 2'd3;
  localparam priv_lvl_t PRIV_LVL_S = 2'd1;
  localparam priv_lvl_t PRIV_LVL_U = 2'd0;

  // --------------------
  // trace record fields
  // --------------------
  typedef enum logic [1:0] {
    KIND_RETIRE    = 2'd0,
    KIND_EXCEPTION = 2'd1,
    KIND_INTERRUPT = 2'd2,
    KIND_ILLEGAL   = 2'd3
  } trace_kind_e;

  // mode letter U, S, M or D
  typedef enum logic [1:0] {
    MODE_U = 2'd0,
    MODE_S = 2'd1,
    MODE_M = 2'd2,
    MODE_D = 2'd3
  } mode_e;

  // control-flow opcodes, instruction bits 6:0
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_BRANCH = 7'b1100011;

  localparam xlen_t CAUSE_ILLEGAL = 32'd2;

  // --------------------
  // event counters
  // --------------------
  localparam int unsigned CNT_RETIRE = 0;
  localparam int unsigned CNT_EXC    = 1;
  localparam int unsigned CNT_IRQ    = 2;
  localparam int unsigned CNT_CFI    = 3;
  localparam int unsigned CNT_DROP   = 4;
  localparam int unsigned NUM_COUNTERS = 5;

  localparam int unsigned DEFAULT_TRACE_DEPTH = 8;

endpackage

// File: hdl/commit_classify.sv
// first observer stage, registers each committed instruction with its kind, mode and cfi flag
`timescale 1ns/100ps

module commit_classify (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // commit port
  input  logic                    commit_valid_i,
  input  trace_pkg::xlen_t        commit_pc_i,
  input  trace_pkg::xlen_t        commit_insn_i,
  input  logic                    commit_ex_valid_i,
  input  trace_pkg::xlen_t        commit_cause_i,
  input  trace_pkg::priv_lvl_t    priv_lvl_i,
  input  logic                    debug_mode_i,
  // classified entry
  output logic                    cls_valid_o,
  output trace_pkg::xlen_t        cls_pc_o,
  output trace_pkg::xlen_t        cls_insn_o,
  output trace_pkg::trace_kind_e  cls_kind_o,
  output trace_pkg::mode_e        cls_mode_o,
  output logic                    cls_cfi_o
);

  import trace_pkg::*;

  trace_kind_e kind_d;
  mode_e       mode_d;
  opcode_t     opcode;
  logic        is_cfi_opc;
  logic        cfi_d;

  // --------------------
  // classification
  // --------------------
  // interrupts carry the top cause bit
  always_comb begin
    if (!commit_ex_valid_i) begin
      kind_d = KIND_RETIRE;
    end else if (commit_cause_i[XLEN-1]) begin
      kind_d = KIND_INTERRUPT;
    end else if (commit_cause_i == CAUSE_ILLEGAL) begin
      kind_d = KIND_ILLEGAL;
    end else begin
      kind_d = KIND_EXCEPTION;
    end
  end

  assign opcode = commit_insn_i[6:0];
  assign is_cfi_opc = (opcode == OPC_JAL) || (opcode == OPC_JALR) || (opcode == OPC_BRANCH);

  // a trapped jump did not change the flow
  assign cfi_d = is_cfi_opc && (kind_d == KIND_RETIRE);

  // debug mode overrides the privilege level
  always_comb begin
    if (debug_mode_i) begin
      mode_d = MODE_D;
    end else begin
      case (priv_lvl_i)
        PRIV_LVL_M: mode_d = MODE_M;
        PRIV_LVL_S: mode_d = MODE_S;
        default:    mode_d = MODE_U;
      endcase
    end
  end

  // --------------------
  // stage register
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cls_valid_o <= 1'b0;
    end else begin
      cls_valid_o <= commit_valid_i;
    end
  end

  // payload only moves with a commit
  always_ff @(posedge clk_i) begin
    if (commit_valid_i) begin
      cls_pc_o   <= commit_pc_i;
      cls_insn_o <= commit_insn_i;
      cls_kind_o <= kind_d;
      cls_mode_o <= mode_d;
      cls_cfi_o  <= cfi_d;
    end
  end

  // the cause decides the kind of every trapped commit
  a_cause_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    commit_valid_i && commit_ex_valid_i |-> !$isunknown(commit_cause_i)
  );

endmodule

// File: hdl/trace_queue.sv
// second observer stage, a circular FIFO of trace records with valid/ready output and drop pulse
`timescale 1ns/100ps

module trace_queue #(
  parameter int unsigned TRACE_DEPTH = trace_pkg::DEFAULT_TRACE_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // from classify stage
  input  logic                    cls_valid_i,
  input  trace_pkg::xlen_t        cls_pc_i,
  input  trace_pkg::xlen_t        cls_insn_i,
  input  trace_pkg::trace_kind_e  cls_kind_i,
  input  trace_pkg::mode_e        cls_mode_i,
  input  logic                    cls_cfi_i,
  // trace output
  output logic                    trace_valid_o,
  input  logic                    trace_ready_i,
  output trace_pkg::xlen_t        trace_pc_o,
  output trace_pkg::xlen_t        trace_insn_o,
  output trace_pkg::trace_kind_e  trace_kind_o,
  output trace_pkg::mode_e        trace_mode_o,
  output logic                    trace_cfi_o,
  output logic                    drop_o
);

  import trace_pkg::*;

  localparam int unsigned PTR_W = (TRACE_DEPTH > 1) ? $clog2(TRACE_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(TRACE_DEPTH + 1);

  xlen_t       pc_mem   [TRACE_DEPTH];
  xlen_t       insn_mem [TRACE_DEPTH];
  trace_kind_e kind_mem [TRACE_DEPTH];
  mode_e       mode_mem [TRACE_DEPTH];
  logic        cfi_mem  [TRACE_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full, push, pop;

  assign full = (count_q == CNT_W'(TRACE_DEPTH));
  assign trace_valid_o = (count_q != '0);
  assign pop = trace_valid_o && trace_ready_i;
  // a pop frees a slot on the same edge
  assign push = cls_valid_i && (!full || pop);
  assign drop_o = cls_valid_i && full && !pop;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(TRACE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(TRACE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      pc_mem[wr_ptr_q]   <= cls_pc_i;
      insn_mem[wr_ptr_q] <= cls_insn_i;
      kind_mem[wr_ptr_q] <= cls_kind_i;
      mode_mem[wr_ptr_q] <= cls_mode_i;
      cfi_mem[wr_ptr_q]  <= cls_cfi_i;
    end
  end

  // head of queue
  assign trace_pc_o   = pc_mem[rd_ptr_q];
  assign trace_insn_o = insn_mem[rd_ptr_q];
  assign trace_kind_o = kind_mem[rd_ptr_q];
  assign trace_mode_o = mode_mem[rd_ptr_q];
  assign trace_cfi_o  = cfi_mem[rd_ptr_q];

  a_count_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) count_q <= CNT_W'(TRACE_DEPTH)
  );

  // a stalled record must not change under the consumer
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    trace_valid_o && !trace_ready_i |=> trace_valid_o && $stable(trace_pc_o) &&
      $stable(trace_insn_o) && $stable(trace_kind_o) && $stable(trace_mode_o) &&
      $stable(trace_cfi_o)
  );

endmodule

// File: hdl/perf_counters.sv
// third observer stage, event counters fed by the classified commits and accessed over APB
`timescale 1ns/100ps

module perf_counters (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // classified events
  input  logic                    cls_valid_i,
  input  trace_pkg::trace_kind_e  cls_kind_i,
  input  trace_pkg::mode_e        cls_mode_i,
  input  logic                    cls_cfi_i,
  input  logic                    drop_i,
  // APB slave, zero wait states
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  trace_pkg::apb_addr_t    paddr_i,
  input  trace_pkg::cnt_t         pwdata_i,
  output trace_pkg::cnt_t         prdata_o,
  output logic                    pslverr_o
);

  import trace_pkg::*;

  localparam int unsigned IDX_W = APB_ADDR_W - 2;

  cnt_t                    cnt_q [NUM_COUNTERS];
  logic [NUM_COUNTERS-1:0] inc;
  logic                    count_en;
  logic                    access;
  logic                    bad_addr;
  logic                    wr_en;
  logic [IDX_W-1:0]        word_idx;

  // --------------------
  // event decode
  // --------------------
  // nothing but drops is counted in debug mode
  assign count_en = cls_valid_i && (cls_mode_i != MODE_D);

  always_comb begin
    inc = '0;
    inc[CNT_RETIRE] = count_en && (cls_kind_i == KIND_RETIRE);
    // illegal instructions are exceptions as well
    inc[CNT_EXC] = count_en &&
                   ((cls_kind_i == KIND_EXCEPTION) || (cls_kind_i == KIND_ILLEGAL));
    inc[CNT_IRQ]  = count_en && (cls_kind_i == KIND_INTERRUPT);
    inc[CNT_CFI]  = count_en && cls_cfi_i;
    inc[CNT_DROP] = drop_i;
  end

  // --------------------
  // APB decode
  // --------------------
  assign access   = psel_i && penable_i;
  assign word_idx = paddr_i[APB_ADDR_W-1:2];
  assign bad_addr = (int'(word_idx) >= NUM_COUNTERS) || (paddr_i[1:0] != 2'b00);
  assign wr_en    = access && pwrite_i && !bad_addr;

  assign pslverr_o = access && bad_addr;

  always_comb begin
    prdata_o = '0;
    if (!bad_addr) begin
      prdata_o = cnt_q[word_idx];
    end
  end

  // --------------------
  // counters
  // --------------------
  // a bus write wins over an event on the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < NUM_COUNTERS; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      for (int k = 0; k < NUM_COUNTERS; k++) begin
        if (wr_en && (int'(word_idx) == k)) begin
          cnt_q[k] <= pwdata_i;
        end else if (inc[k]) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

  // access phase always follows a setup phase
  a_apb_setup: assert property (
    @(posedge clk_i) disable iff (!rst_ni) penable_i |-> $past(psel_i)
  );

endmodule

// File: hdl/commit_trace_top.sv
// top level of the commit trace observer, chains classify, trace queue and counters
`timescale 1ns/100ps

module commit_trace_top #(
  parameter int unsigned TRACE_DEPTH = trace_pkg::DEFAULT_TRACE_DEPTH
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // commit port
  input  logic                    commit_valid_i,
  input  trace_pkg::xlen_t        commit_pc_i,
  input  trace_pkg::xlen_t        commit_insn_i,
  input  logic                    commit_ex_valid_i,
  input  trace_pkg::xlen_t        commit_cause_i,
  input  trace_pkg::priv_lvl_t    priv_lvl_i,
  input  logic                    debug_mode_i,
  // trace port
  output logic                    trace_valid_o,
  input  logic                    trace_ready_i,
  output trace_pkg::xlen_t        trace_pc_o,
  output trace_pkg::xlen_t        trace_insn_o,
  output trace_pkg::trace_kind_e  trace_kind_o,
  output trace_pkg::mode_e        trace_mode_o,
  output logic                    trace_cfi_o,
  // APB counter access
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  trace_pkg::apb_addr_t    paddr_i,
  input  trace_pkg::cnt_t         pwdata_i,
  output trace_pkg::cnt_t         prdata_o,
  output logic                    pslverr_o
);

  import trace_pkg::*;

  // classify stage outputs
  logic        cls_valid;
  xlen_t       cls_pc;
  xlen_t       cls_insn;
  trace_kind_e cls_kind;
  mode_e       cls_mode;
  logic        cls_cfi;
  logic        drop;

  commit_classify u_commit_classify (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_valid_i    ( commit_valid_i    ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_insn_i     ( commit_insn_i     ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_cause_i    ( commit_cause_i    ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .cls_valid_o       ( cls_valid         ),
    .cls_pc_o          ( cls_pc            ),
    .cls_insn_o        ( cls_insn          ),
    .cls_kind_o        ( cls_kind          ),
    .cls_mode_o        ( cls_mode          ),
    .cls_cfi_o         ( cls_cfi           )
  );

  trace_queue #(
    .TRACE_DEPTH ( TRACE_DEPTH )
  ) u_trace_queue (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .cls_valid_i   ( cls_valid     ),
    .cls_pc_i      ( cls_pc        ),
    .cls_insn_i    ( cls_insn      ),
    .cls_kind_i    ( cls_kind      ),
    .cls_mode_i    ( cls_mode      ),
    .cls_cfi_i     ( cls_cfi       ),
    .trace_valid_o ( trace_valid_o ),
    .trace_ready_i ( trace_ready_i ),
    .trace_pc_o    ( trace_pc_o    ),
    .trace_insn_o  ( trace_insn_o  ),
    .trace_kind_o  ( trace_kind_o  ),
    .trace_mode_o  ( trace_mode_o  ),
    .trace_cfi_o   ( trace_cfi_o   ),
    .drop_o        ( drop          )
  );

  perf_counters u_perf_counters (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .cls_valid_i ( cls_valid ),
    .cls_kind_i  ( cls_kind  ),
    .cls_mode_i  ( cls_mode  ),
    .cls_cfi_i   ( cls_cfi   ),
    .drop_i      ( drop      ),
    .psel_i      ( psel_i    ),
    .penable_i   ( penable_i ),
    .pwrite_i    ( pwrite_i  ),
    .paddr_i     ( paddr_i   ),
    .pwdata_i    ( pwdata_i  ),
    .prdata_o    ( prdata_o  ),
    .pslverr_o   ( pslverr_o )
  );

endmodule

// File: tests/tb_clk_gen.sv
// testbench clock and reset source, free running clock with an active low reset pulse
`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 40,
  parameter int unsigned RST_CYCLES = 2
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release away from the active edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: tests/tb_commit_trace.sv
// testbench of the commit trace observer that runs a stimulus table against a reference model
`timescale 1ns/100ps

module tb_commit_trace;

  import trace_pkg::*;

  localparam int unsigned TRACE_DEPTH = DEFAULT_TRACE_DEPTH;
  localparam xlen_t INSN_ADDI   = 32'h0010_0093;
  localparam xlen_t INSN_LOAD   = 32'h0000_a103;
  localparam xlen_t INSN_JAL    = 32'h0080_00ef;
  localparam xlen_t INSN_JALR   = 32'h0000_80e7;
  localparam xlen_t INSN_BRANCH = 32'h0020_8463;

  logic        clk, rst_n;
  logic        commit_valid, commit_ex, debug_mode, trace_ready;
  xlen_t       commit_pc, commit_insn, commit_cause;
  priv_lvl_t   priv_lvl;
  logic        trace_valid, trace_cfi;
  xlen_t       trace_pc, trace_insn;
  trace_kind_e trace_kind;
  mode_e       trace_mode;
  logic        psel, penable, pwrite, pslverr;
  apb_addr_t   paddr;
  cnt_t        pwdata, prdata;

  // stimulus table with apb op 0 for none, 1 for read and 2 for write
  string     t_name[$];
  logic      t_valid[$], t_ex[$], t_dbg[$], t_ready[$], t_err[$];
  xlen_t     t_pc[$], t_insn[$], t_cause[$];
  priv_lvl_t t_priv[$];
  int        t_apb[$];
  apb_addr_t t_addr[$];
  cnt_t      t_wdata[$];

  // model state
  string       q_name[$];
  xlen_t       q_pc[$], q_insn[$];
  trace_kind_e q_kind[$];
  mode_e       q_mode[$];
  logic        q_cfi[$];
  cnt_t        m_cnt[NUM_COUNTERS];
  logic        p_valid, p_cfi;
  string       p_name;
  xlen_t       p_pc, p_insn;
  trace_kind_e p_kind;
  mode_e       p_mode;

  string       cur_name;
  logic        apb_exp_err;
  logic        exp_valid, full, pop;
  int          idx;
  int          errors, checks, cycle_cnt, timeout_limit;
  logic [31:0] lfsr;

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_tb_clk_gen (.clk_o(clk), .rst_no(rst_n));

  commit_trace_top #(.TRACE_DEPTH(TRACE_DEPTH)) u_commit_trace_top (
    .clk_i(clk), .rst_ni(rst_n),
    .commit_valid_i(commit_valid), .commit_pc_i(commit_pc), .commit_insn_i(commit_insn),
    .commit_ex_valid_i(commit_ex), .commit_cause_i(commit_cause), .priv_lvl_i(priv_lvl),
    .debug_mode_i(debug_mode),
    .trace_valid_o(trace_valid), .trace_ready_i(trace_ready), .trace_pc_o(trace_pc),
    .trace_insn_o(trace_insn), .trace_kind_o(trace_kind), .trace_mode_o(trace_mode),
    .trace_cfi_o(trace_cfi),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pslverr_o(pslverr)
  );

  // --------------------
  // helpers
  // --------------------
  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  function automatic xlen_t random_pc();
    logic [29:0] bits;
    bits = '0;
    for (int b = 0; b < 30; b++) begin
      bits = {bits[28:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return {bits, 2'b00};
  endfunction

  function automatic trace_kind_e expect_kind(input logic ex, input xlen_t cause);
    if (!ex) return KIND_RETIRE;
    if (cause[31]) return KIND_INTERRUPT;
    if (cause == CAUSE_ILLEGAL) return KIND_ILLEGAL;
    return KIND_EXCEPTION;
  endfunction

  function automatic mode_e expect_mode(input logic dbg, input priv_lvl_t priv);
    if (dbg) return MODE_D;
    if (priv == PRIV_LVL_M) return MODE_M;
    if (priv == PRIV_LVL_S) return MODE_S;
    return MODE_U;
  endfunction

  task automatic push_entry(input string name, input logic valid, input xlen_t insn,
                            input logic ex, input xlen_t cause, input priv_lvl_t priv,
                            input logic dbg, input logic ready, input int apb,
                            input apb_addr_t addr, input cnt_t wdata, input logic err);
    t_name.push_back(name);
    t_valid.push_back(valid);
    t_pc.push_back(random_pc());
    t_insn.push_back(insn);
    t_ex.push_back(ex);
    t_cause.push_back(cause);
    t_priv.push_back(priv);
    t_dbg.push_back(dbg);
    t_ready.push_back(ready);
    t_apb.push_back(apb);
    t_addr.push_back(addr);
    t_wdata.push_back(wdata);
    t_err.push_back(err);
  endtask

  task automatic add_commit(input string name, input xlen_t insn, input logic ex,
                            input xlen_t cause, input priv_lvl_t priv, input logic dbg,
                            input logic ready);
    push_entry(name, 1'b1, insn, ex, cause, priv, dbg, ready, 0, '0, '0, 1'b0);
  endtask

  task automatic add_idle(input string name, input logic ready);
    push_entry(name, 1'b0, INSN_ADDI, 1'b0, '0, PRIV_LVL_M, 1'b0, ready, 0, '0, '0, 1'b0);
  endtask

  task automatic add_apb(input string name, input logic wr, input apb_addr_t addr,
                         input cnt_t wdata, input logic err);
    push_entry(name, 1'b0, INSN_ADDI, 1'b0, '0, PRIV_LVL_M, 1'b0, 1'b1, wr ? 2 : 1,
               addr, wdata, err);
  endtask

  task automatic report_mismatch(input string name, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("ERR %s %s expected %h actual %h", name, what, exp, act);
  endtask

  task automatic build_table();
    add_commit("ret_m", INSN_ADDI, 1'b0, '0, PRIV_LVL_M, 1'b0, 1'b1);
    add_commit("ret_s", INSN_LOAD, 1'b0, '0, PRIV_LVL_S, 1'b0, 1'b1);
    add_commit("ret_u", INSN_ADDI, 1'b0, '0, PRIV_LVL_U, 1'b0, 1'b1);
    add_commit("exc_load", INSN_LOAD, 1'b1, 32'd5, PRIV_LVL_M, 1'b0, 1'b1);
    add_commit("irq_timer", INSN_ADDI, 1'b1, 32'h8000_0007, PRIV_LVL_S, 1'b0, 1'b1);
    add_commit("illegal", 32'h0000_0000, 1'b1, CAUSE_ILLEGAL, PRIV_LVL_U, 1'b0, 1'b1);
    add_commit("irq_ext", INSN_ADDI, 1'b1, 32'h8000_000b, PRIV_LVL_M, 1'b0, 1'b1);
    add_commit("cfi_jal", INSN_JAL, 1'b0, '0, PRIV_LVL_M, 1'b0, 1'b1);
    add_commit("cfi_jalr", INSN_JALR, 1'b0, '0, PRIV_LVL_S, 1'b0, 1'b1);
    add_commit("cfi_branch", INSN_BRANCH, 1'b0, '0, PRIV_LVL_U, 1'b0, 1'b1);
    add_commit("exc_jalr", INSN_JALR, 1'b1, 32'd1, PRIV_LVL_M, 1'b0, 1'b1);
    add_apb("rd_retire", 1'b0, 5'h00, '0, 1'b0);
    add_apb("rd_exc", 1'b0, 5'h04, '0, 1'b0);
    add_apb("rd_irq", 1'b0, 5'h08, '0, 1'b0);
    add_apb("rd_cfi", 1'b0, 5'h0c, '0, 1'b0);
    // with ready low the queue keeps TRACE_DEPTH records and drops the rest
    for (int i = 0; i < TRACE_DEPTH + 4; i++) begin
      add_commit($sformatf("fill_%0d", i), INSN_ADDI, 1'b0, '0, PRIV_LVL_M, 1'b0, 1'b0);
    end
    add_idle("hold", 1'b0);
    for (int i = 0; i < TRACE_DEPTH + 2; i++) begin
      add_idle("drain", 1'b1);
    end
    add_apb("rd_drop", 1'b0, 5'h10, '0, 1'b0);
    add_apb("wr_retire", 1'b1, 5'h00, 32'd100, 1'b0);
    add_commit("after_wr_0", INSN_ADDI, 1'b0, '0, PRIV_LVL_S, 1'b0, 1'b1);
    add_commit("after_wr_1", INSN_LOAD, 1'b0, '0, PRIV_LVL_U, 1'b0, 1'b1);
    add_apb("rd_after_wr", 1'b0, 5'h00, '0, 1'b0);
    add_apb("wr_bad", 1'b1, 5'h14, 32'hdead_beef, 1'b1);
    add_apb("rd_bad", 1'b0, 5'h1c, '0, 1'b1);
    // debug mode is traced but not counted
    add_commit("dbg_ret", INSN_ADDI, 1'b0, '0, PRIV_LVL_M, 1'b1, 1'b1);
    add_commit("dbg_jal", INSN_JAL, 1'b0, '0, PRIV_LVL_U, 1'b1, 1'b1);
    add_commit("dbg_exc", INSN_LOAD, 1'b1, 32'd5, PRIV_LVL_M, 1'b1, 1'b1);
    add_apb("rd_retire_dbg", 1'b0, 5'h00, '0, 1'b0);
    add_apb("rd_cfi_dbg", 1'b0, 5'h0c, '0, 1'b0);
    add_apb("rd_exc_dbg", 1'b0, 5'h04, '0, 1'b0);
    add_idle("tail", 1'b1);
  endtask

  // --------------------
  // model and checks sampled mid cycle
  // --------------------
  always @(negedge clk) begin
    if (rst_n) begin
      exp_valid = (q_pc.size() != 0);
      full = (q_pc.size() == TRACE_DEPTH);
      pop = exp_valid && trace_ready;
      checks++;
      if (trace_valid !== exp_valid) report_mismatch(cur_name, "valid", exp_valid, trace_valid);
      if (pop && trace_valid) begin
        checks += 5;
        if (trace_pc !== q_pc[0]) report_mismatch(q_name[0], "pc", q_pc[0], trace_pc);
        if (trace_insn !== q_insn[0]) report_mismatch(q_name[0], "insn", q_insn[0], trace_insn);
        if (trace_kind !== q_kind[0]) report_mismatch(q_name[0], "kind", q_kind[0], trace_kind);
        if (trace_mode !== q_mode[0]) report_mismatch(q_name[0], "mode", q_mode[0], trace_mode);
        if (trace_cfi !== q_cfi[0]) report_mismatch(q_name[0], "cfi", q_cfi[0], trace_cfi);
      end
      if (pop) begin
        void'(q_name.pop_front());
        void'(q_pc.pop_front());
        void'(q_insn.pop_front());
        void'(q_kind.pop_front());
        void'(q_mode.pop_front());
        void'(q_cfi.pop_front());
      end
      // access phase of an apb transfer
      idx = int'(paddr[4:2]);
      if (psel && penable) begin
        checks++;
        if (pslverr !== apb_exp_err) report_mismatch(cur_name, "pslverr", apb_exp_err, pslverr);
        if (!pwrite && !apb_exp_err) begin
          checks++;
          if (prdata !== m_cnt[idx]) report_mismatch(cur_name, "prdata", m_cnt[idx], prdata);
        end
      end else begin
        checks++;
        if (pslverr !== 1'b0) report_mismatch(cur_name, "pslverr", 1'b0, pslverr);
      end
      // classified entry lands in the queue and counters on the next edge
      if (p_valid) begin
        if (!full || pop) begin
          q_name.push_back(p_name);
          q_pc.push_back(p_pc);
          q_insn.push_back(p_insn);
          q_kind.push_back(p_kind);
          q_mode.push_back(p_mode);
          q_cfi.push_back(p_cfi);
        end else begin
          m_cnt[CNT_DROP] = m_cnt[CNT_DROP] + 1;
        end
        if (p_mode != MODE_D) begin
          if (p_kind == KIND_RETIRE) m_cnt[CNT_RETIRE] = m_cnt[CNT_RETIRE] + 1;
          if (p_kind == KIND_INTERRUPT) m_cnt[CNT_IRQ] = m_cnt[CNT_IRQ] + 1;
          if (p_kind == KIND_EXCEPTION || p_kind == KIND_ILLEGAL) begin
            m_cnt[CNT_EXC] = m_cnt[CNT_EXC] + 1;
          end
          if (p_cfi) m_cnt[CNT_CFI] = m_cnt[CNT_CFI] + 1;
        end
      end
      // bus write wins over an event on the same edge
      if (psel && penable && pwrite && !apb_exp_err) m_cnt[idx] = pwdata;
      p_valid = commit_valid;
      p_name = cur_name;
      p_pc = commit_pc;
      p_insn = commit_insn;
      p_kind = expect_kind(commit_ex, commit_cause);
      p_mode = expect_mode(debug_mode, priv_lvl);
      p_cfi = !commit_ex && (commit_insn[6:0] == OPC_JAL || commit_insn[6:0] == OPC_JALR ||
                             commit_insn[6:0] == OPC_BRANCH);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_limit) begin
      $display("timeout after %0d cycles, the stimulus table did not finish", cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  // --------------------
  // driver
  // --------------------
  initial begin
    commit_valid = 1'b0;
    commit_pc = '0;
    commit_insn = '0;
    commit_ex = 1'b0;
    commit_cause = '0;
    priv_lvl = PRIV_LVL_M;
    debug_mode = 1'b0;
    trace_ready = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    p_valid = 1'b0;
    apb_exp_err = 1'b0;
    cur_name = "reset";
    errors = 0;
    checks = 0;
    cycle_cnt = 0;
    lfsr = 32'd50;
    for (int k = 0; k < NUM_COUNTERS; k++) begin
      m_cnt[k] = '0;
    end
    build_table();
    timeout_limit = t_name.size() * 4 + 50;
    @(posedge rst_n);
    for (int i = 0; i < t_name.size(); i++) begin
      @(posedge clk);
      cur_name = t_name[i];
      apb_exp_err = t_err[i];
      commit_valid <= t_valid[i];
      commit_pc <= t_pc[i];
      commit_insn <= t_insn[i];
      commit_ex <= t_ex[i];
      commit_cause <= t_cause[i];
      priv_lvl <= t_priv[i];
      debug_mode <= t_dbg[i];
      trace_ready <= t_ready[i];
      psel <= (t_apb[i] != 0);
      penable <= 1'b0;
      pwrite <= (t_apb[i] == 2);
      paddr <= t_addr[i];
      pwdata <= t_wdata[i];
      if (t_apb[i] != 0) begin
        @(posedge clk);
        penable <= 1'b1;
      end
    end
    @(posedge clk);
    commit_valid <= 1'b0;
    psel <= 1'b0;
    penable <= 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (q_pc.size() != 0 || p_valid) begin
      errors++;
      $display("records still waiting in the model queue at the end of the run");
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: project.f
hdl/trace_pkg.sv
hdl/commit_classify.sv
hdl/trace_queue.sv
hdl/perf_counters.sv
hdl/commit_trace_top.sv
tests/tb_clk_gen.sv
tests/tb_commit_trace.sv

// File: run.sh
#!/bin/sh
# Build and run the commit trace testbench with Verilator.
# Exits non-zero on a build error, a simulator error or a missing pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_commit_trace

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_commit_trace \
  -f project.f -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
